// ==== Bender.yml ====
package:
  name: rmii_transmitter

sources:
  # Packages first, then the RTL in dependency order
  - files:
      - design/rmii_types_pkg.sv
      - design/rmii_timing_pkg.sv
      - design/tx_byte_fifo.sv
      - design/fcs_appender.sv
      - design/rmii_byte_shipper.sv
      - design/rmii_transmitter.sv

  - target: test
    files:
      - verification/rmii_transmitter_tb.sv

// ==== design/fcs_appender.sv ====
`default_nettype none

module fcs_appender (
    input  wire                                 clock,
    input  wire                                 reset_n,
    input  wire rmii_types_pkg::fifo_word_t     fifo_word,
    input  wire                                 fifo_valid,
    output logic                                fifo_pop,
    output rmii_types_pkg::stream_word_t        data,
    output logic                                data_enable,
    input  wire                                 data_ready
);

    import rmii_types_pkg::*;
    import rmii_timing_pkg::*;

    typedef enum logic [1:0] {
        FIRST,
        BODY,
        FCS
    } state_t;

    state_t         state;
    state_t         _state;
    crc_t           crc;
    crc_t           _crc;
    logic [1:0]     fcs_index;
    logic [1:0]     _fcs_index;
    octet_t         head_byte;
    logic           head_last;
    octet_t         fcs_byte;

    // One byte through the reflected CRC-32, lsb first
    function automatic crc_t crc_update(input crc_t value, input octet_t octet);
        crc_t result;
        result = value ^ {24'd0, octet};
        for (int i = 0; i < 8; i++) begin
            if (result[0]) begin
                result = (result >> 1) ^ CRC_POLYNOMIAL;
            end
            else begin
                result = result >> 1;
            end
        end
        return result;
    endfunction

    assign head_byte = fifo_word[7:0];
    assign head_last = fifo_word[8];

    // FCS goes out inverted, lowest byte first
    assign fcs_byte = ~crc[{fcs_index, 3'b000} +: 8];

    ////////////////////////////////////////////////////////////
    // Word presented to the shipper
    ////////////////////////////////////////////////////////////

    always_comb begin
        data        = {1'b0, head_byte};
        data_enable = fifo_valid;
        fifo_pop    = 1'b0;

        case (state)
            FIRST: begin
                data     = {1'b1, head_byte};
                fifo_pop = data_ready;
            end
            BODY: begin
                fifo_pop = data_ready;
            end
            FCS: begin
                // Buffer head is held back until all four bytes are out
                data        = {1'b0, fcs_byte};
                data_enable = 1'b1;
            end
            default: begin
                fifo_pop = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Frame tracking and CRC accumulation
    ////////////////////////////////////////////////////////////

    always_comb begin
        _state     = state;
        _crc       = crc;
        _fcs_index = fcs_index;

        case (state)
            FIRST, BODY: begin
                if (data_ready) begin
                    _crc = crc_update(crc, head_byte);
                    if (head_last) begin
                        _state     = FCS;
                        _fcs_index = 2'd0;
                    end
                    else begin
                        _state = BODY;
                    end
                end
            end
            FCS: begin
                if (data_ready) begin
                    _fcs_index = fcs_index + 2'd1;
                    if (fcs_index == 2'd3) begin
                        _state = FIRST;
                        _crc   = CRC_INIT;
                    end
                end
            end
            default: begin
                _state = FIRST;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state     <= FIRST;
            crc       <= CRC_INIT;
            fcs_index <= 2'd0;
        end
        else begin
            state     <= _state;
            crc       <= _crc;
            fcs_index <= _fcs_index;
        end
    end

    // Shipper only accepts what is on offer
    assert property (@(posedge clock) disable iff (!reset_n)
        data_ready |-> data_enable);

endmodule

`default_nettype wire

// ==== design/rmii_byte_shipper.sv ====
`default_nettype none

module rmii_byte_shipper (
    input  wire                                 clock,
    input  wire                                 reset_n,
    input  wire rmii_types_pkg::stream_word_t   data,
    input  wire                                 data_enable,
    input  wire rmii_types_pkg::speed_code_t    speed_code,
    output rmii_types_pkg::dibit_t              shipped_data,
    output logic                                shipped_data_valid,
    output logic                                data_ready
);

    import rmii_types_pkg::*;
    import rmii_timing_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        START_OF_FRAME,
        DATA,
        GAP
    } state_t;

    state_t         state;
    state_t         _state;
    speed_code_t    saved_speed_code;
    speed_code_t    _saved_speed_code;
    logic [8:0]     sample_limit;
    logic [15:0]    preamble_limit;
    logic [15:0]    preamble_counter;
    logic [15:0]    _preamble_counter;
    logic [1:0]     dibit_counter;
    logic [1:0]     _dibit_counter;
    logic [8:0]     hold_counter;
    logic [8:0]     _hold_counter;
    octet_t         byte_to_ship;
    octet_t         _byte_to_ship;
    dibit_t         _shipped_data;
    logic           _shipped_data_valid;

    ////////////////////////////////////////////////////////////
    // Limits for the speed latched at frame start
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (saved_speed_code)
            SPEED_CODE_10_MEGABIT: begin
                sample_limit   = SAMPLE_LIMIT_10;
                preamble_limit = PREAMBLE_LIMIT_10;
            end
            SPEED_CODE_100_MEGABIT: begin
                sample_limit   = SAMPLE_LIMIT_100;
                preamble_limit = PREAMBLE_LIMIT_100;
            end
            default: begin
                sample_limit   = SAMPLE_LIMIT_100;
                preamble_limit = PREAMBLE_LIMIT_100;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Line FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        _state              = state;
        _saved_speed_code   = saved_speed_code;
        _preamble_counter   = preamble_counter;
        _dibit_counter      = dibit_counter;
        _hold_counter       = hold_counter;
        _byte_to_ship       = byte_to_ship;
        _shipped_data       = shipped_data;
        _shipped_data_valid = shipped_data_valid;
        data_ready          = 1'b0;

        case (state)
            IDLE: begin
                _shipped_data       = 2'b00;
                _shipped_data_valid = 1'b0;
                _saved_speed_code   = speed_code;
                _preamble_counter   = '0;
                _dibit_counter      = '0;
                _hold_counter       = '0;

                // Leftover unmarked words are drained and dropped
                if (data_enable) begin
                    data_ready = 1'b1;
                    if (data[8]) begin
                        _byte_to_ship       = data[7:0];
                        _shipped_data       = 2'b01;
                        _shipped_data_valid = 1'b1;
                        _state              = PREAMBLE;
                    end
                end
            end
            PREAMBLE: begin
                if (preamble_counter == preamble_limit) begin
                    _preamble_counter = '0;
                    _state            = START_OF_FRAME;
                end
                else begin
                    _preamble_counter = preamble_counter + 16'd1;
                end
            end
            START_OF_FRAME: begin
                _shipped_data = 2'b11;
                if (hold_counter == sample_limit) begin
                    _hold_counter = '0;
                    _state        = DATA;
                end
                else begin
                    _hold_counter = hold_counter + 9'd1;
                end
            end
            DATA: begin
                _shipped_data = byte_to_ship[1:0];
                if (hold_counter == sample_limit) begin
                    _hold_counter  = '0;
                    _byte_to_ship  = {2'b00, byte_to_ship[7:2]};
                    _dibit_counter = dibit_counter + 2'd1;

                    // Fetch while the last dibit of this byte is being loaded
                    if (dibit_counter == 2'd3) begin
                        if (data_enable && !data[8]) begin
                            data_ready    = 1'b1;
                            _byte_to_ship = data[7:0];
                        end
                        else begin
                            // Next frame start or underrun ends this frame
                            _state        = GAP;
                            _hold_counter = INTER_PACKET_GAP_CYCLES[8:0];
                        end
                    end
                end
                else begin
                    _hold_counter = hold_counter + 9'd1;
                end
            end
            GAP: begin
                _shipped_data       = 2'b00;
                _shipped_data_valid = 1'b0;
                if (hold_counter == '0) begin
                    _state = IDLE;
                end
                else begin
                    _hold_counter = hold_counter - 9'd1;
                end
            end
            default: begin
                _state = IDLE;
            end
        endcase
    end

    // Byte being shifted onto the line
    always_ff @(posedge clock) begin
        byte_to_ship <= _byte_to_ship;
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state              <= IDLE;
            saved_speed_code   <= SPEED_CODE_100_MEGABIT;
            preamble_counter   <= '0;
            dibit_counter      <= '0;
            hold_counter       <= '0;
            shipped_data       <= 2'b00;
            shipped_data_valid <= 1'b0;
        end
        else begin
            state              <= _state;
            saved_speed_code   <= _saved_speed_code;
            preamble_counter   <= _preamble_counter;
            dibit_counter      <= _dibit_counter;
            hold_counter       <= _hold_counter;
            shipped_data       <= _shipped_data;
            shipped_data_valid <= _shipped_data_valid;
        end
    end

    // tx_en has dropped by the time the gap has run out
    assert property (@(posedge clock) disable iff (!reset_n)
        (state == IDLE) |-> !shipped_data_valid);

endmodule

`default_nettype wire

// ==== design/rmii_timing_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// Line timing, speed codes and CRC constants
////////////////////////////////////////////////////////////

package rmii_timing_pkg;

    // Unknown codes fall back to 100 Mbit/s
    localparam rmii_types_pkg::speed_code_t SPEED_CODE_100_MEGABIT = 2'd1;
    localparam rmii_types_pkg::speed_code_t SPEED_CODE_10_MEGABIT  = 2'd0;

    // Last index of the per-dibit hold counter
    localparam logic [8:0]  SAMPLE_LIMIT_100   = 9'd0;
    localparam logic [8:0]  SAMPLE_LIMIT_10    = 9'd9;

    localparam logic [15:0] PREAMBLE_LIMIT_100 = 16'd26;
    localparam logic [15:0] PREAMBLE_LIMIT_10  = 16'd260;

    // 9.6 us at the 50 MHz reference clock
    localparam logic [15:0] INTER_PACKET_GAP_CYCLES = 16'd480;

    // Reflected form, bytes enter least significant bit first
    localparam rmii_types_pkg::crc_t CRC_POLYNOMIAL = 32'hEDB8_8320;
    localparam rmii_types_pkg::crc_t CRC_INIT       = 32'hFFFF_FFFF;

    localparam int TX_FIFO_DEPTH = 64;

endpackage

`default_nettype wire

// ==== design/rmii_transmitter.sv ====
`default_nettype none

module rmii_transmitter (
    input  wire                                 clock,
    input  wire                                 reset_n,
    input  wire rmii_types_pkg::octet_t         write_data,
    input  wire                                 write_last,
    input  wire                                 write_enable,
    output logic                                full,
    input  wire rmii_types_pkg::speed_code_t    speed_code,
    output rmii_types_pkg::dibit_t              txd,
    output logic                                tx_en
);

    import rmii_types_pkg::*;

    // Buffer head towards the appender
    fifo_word_t     fifo_word;
    logic           fifo_valid;
    logic           fifo_pop;

    // Byte stream with FCS towards the shipper
    stream_word_t   stream_data;
    logic           stream_enable;
    logic           stream_ready;

    tx_byte_fifo tx_byte_fifo_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .write_word   ({write_last, write_data}),
        .write_enable (write_enable),
        .full         (full),
        .fifo_word    (fifo_word),
        .fifo_valid   (fifo_valid),
        .fifo_pop     (fifo_pop)
    );

    fcs_appender fcs_appender_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .fifo_word   (fifo_word),
        .fifo_valid  (fifo_valid),
        .fifo_pop    (fifo_pop),
        .data        (stream_data),
        .data_enable (stream_enable),
        .data_ready  (stream_ready)
    );

    rmii_byte_shipper rmii_byte_shipper_i (
        .clock              (clock),
        .reset_n            (reset_n),
        .data               (stream_data),
        .data_enable        (stream_enable),
        .speed_code         (speed_code),
        .shipped_data       (txd),
        .shipped_data_valid (tx_en),
        .data_ready         (stream_ready)
    );

endmodule

`default_nettype wire

// ==== design/rmii_types_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// Data types shared by the RMII transmit path
////////////////////////////////////////////////////////////

package rmii_types_pkg;

    // One byte of frame payload
    typedef logic [7:0] octet_t;

    // Word handed to the shipper, bit 8 marks the first byte of a frame
    typedef logic [8:0] stream_word_t;

    // Buffer entry, bit 8 marks the last byte of a frame
    typedef logic [8:0] fifo_word_t;

    // One RMII transmit symbol
    typedef logic [1:0] dibit_t;

    // Line speed selector
    typedef logic [1:0] speed_code_t;

    // Ethernet frame check sequence register
    typedef logic [31:0] crc_t;

endpackage

`default_nettype wire

// ==== design/tx_byte_fifo.sv ====
`default_nettype none

module tx_byte_fifo #(
    parameter int DEPTH = rmii_timing_pkg::TX_FIFO_DEPTH
) (
    input  wire                                 clock,
    input  wire                                 reset_n,
    input  wire rmii_types_pkg::fifo_word_t     write_word,
    input  wire                                 write_enable,
    output logic                                full,
    output rmii_types_pkg::fifo_word_t          fifo_word,
    output logic                                fifo_valid,
    input  wire                                 fifo_pop
);

    import rmii_types_pkg::*;

    // DEPTH is a power of two so the pointers wrap on their own
    localparam int POINTER_WIDTH = $clog2(DEPTH);
    localparam int COUNT_WIDTH   = $clog2(DEPTH + 1);

    fifo_word_t                 memory [DEPTH];
    logic [POINTER_WIDTH-1:0]   write_pointer;
    logic [POINTER_WIDTH-1:0]   read_pointer;
    logic [COUNT_WIDTH-1:0]     count;
    logic                       do_write;
    logic                       do_read;

    assign full       = (count == COUNT_WIDTH'(DEPTH));
    assign fifo_valid = (count != '0);
    assign fifo_word  = memory[read_pointer];

    assign do_write = write_enable && !full;
    assign do_read  = fifo_pop && fifo_valid;

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (do_write) begin
            memory[write_pointer] <= write_word;
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            write_pointer <= '0;
            read_pointer  <= '0;
            count         <= '0;
        end
        else begin
            if (do_write) begin
                write_pointer <= write_pointer + POINTER_WIDTH'(1);
            end
            if (do_read) begin
                read_pointer <= read_pointer + POINTER_WIDTH'(1);
            end

            // Simultaneous write and pop leaves the count alone
            case ({do_write, do_read})
                2'b10:   count <= count + COUNT_WIDTH'(1);
                2'b01:   count <= count - COUNT_WIDTH'(1);
                default: count <= count;
            endcase
        end
    end

    // The appender only pops an entry it is presenting
    assert property (@(posedge clock) disable iff (!reset_n)
        fifo_pop |-> fifo_valid);

endmodule

`default_nettype wire

// ==== verification/rmii_transmitter_tb.sv ====
`default_nettype none

module rmii_transmitter_tb;

    import rmii_types_pkg::*;
    import rmii_timing_pkg::*;

    localparam int DEPTH          = TX_FIFO_DEPTH;
    localparam int TOTAL_FRAMES   = 12;
    localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * (2 * 40 * 4 * 10 + 600);

    logic           clock = 1'b0;
    logic           reset_n;
    octet_t         write_data;
    logic           write_last;
    logic           write_enable;
    logic           full;
    speed_code_t    speed_code;
    dibit_t         txd;
    logic           tx_en;

    int             seed;
    int             cycle_count = 0;
    int             value_errors = 0;
    int             structural_errors = 0;
    int             frames_written = 0;
    int             frames_checked = 0;

    // Written frames, flattened, and what came off the line
    octet_t         expected_bytes[$];
    int             expected_lengths[$];
    speed_code_t    expected_speeds[$];
    octet_t         received_bytes[$];
    int             received_lengths[$];

    ////////////////////////////////////////////////////////////
    // Reference model and compare tasks
    ////////////////////////////////////////////////////////////

    // Bitwise LFSR form of the Ethernet CRC returning the FCS as sent
    function automatic crc_t crc32_of(input octet_t frame_bytes[$]);
        crc_t remainder;
        logic feedback;
        remainder = CRC_INIT;
        foreach (frame_bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                feedback  = remainder[0] ^ frame_bytes[i][b];
                remainder = remainder >> 1;
                if (feedback) begin
                    remainder = remainder ^ CRC_POLYNOMIAL;
                end
            end
        end
        return ~remainder;
    endfunction

    task automatic check_octet(input string name, input octet_t actual, input octet_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            value_errors++;
        end
    endtask

    task automatic check_dibit(input string name, input dibit_t actual, input dibit_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            value_errors++;
        end
    endtask

    task automatic check_crc(input string name, input crc_t actual, input crc_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            value_errors++;
        end
    endtask

    task automatic check_level(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            value_errors++;
        end
    endtask

    task automatic report_error(input string text);
        $display("ERROR: %s", text);
        structural_errors++;
    endtask

    ////////////////////////////////////////////////////////////
    // Host side stimulus
    ////////////////////////////////////////////////////////////

    // Holds the byte back while the buffer reports full
    task automatic push_byte(input octet_t value, input logic last);
        @(posedge clock);
        #5;
        while (full) begin
            write_enable = 1'b0;
            @(posedge clock);
            #5;
        end
        write_data   = value;
        write_last   = last;
        write_enable = 1'b1;
    endtask

    task automatic drive_idle();
        @(posedge clock);
        #5;
        write_enable = 1'b0;
        write_last   = 1'b0;
    endtask

    task automatic set_speed(input speed_code_t code);
        @(posedge clock);
        #5;
        speed_code = code;
    endtask

    task automatic write_random_frame();
        int     length;
        octet_t value;
        length = 1 + ({$random(seed)} % 40);
        expected_speeds.push_back(speed_code);
        for (int i = 0; i < length; i++) begin
            value = octet_t'($random(seed));
            push_byte(value, i == length - 1);
            expected_bytes.push_back(value);
        end
        expected_lengths.push_back(length);
        frames_written++;
        drive_idle();
    endtask

    // Fills the buffer faster than the 10 Mbit/s line drains it
    task automatic fill_buffer_frame();
        int     accepted;
        logic   filled;
        octet_t value;
        accepted = 0;
        filled   = 1'b0;
        expected_speeds.push_back(speed_code);
        while (!filled && accepted <= DEPTH + 1) begin
            @(posedge clock);
            #5;
            if (full) begin
                filled = 1'b1;
            end
            else begin
                value        = octet_t'($random(seed));
                write_data   = value;
                write_last   = 1'b0;
                write_enable = 1'b1;
                expected_bytes.push_back(value);
                accepted++;
            end
        end
        if (!filled) begin
            report_error($sformatf("full did not rise after %0d writes", accepted));
        end
        else if (accepted < DEPTH) begin
            report_error($sformatf("full rose after only %0d writes", accepted));
        end

        // This byte must be dropped
        write_data = 8'h5A;
        @(posedge clock);
        #5;
        write_enable = 1'b0;
        check_level("full", full, 1'b1);

        value = octet_t'($random(seed));
        push_byte(value, 1'b1);
        expected_bytes.push_back(value);
        expected_lengths.push_back(accepted + 1);
        frames_written++;
        drive_idle();
    endtask

    task automatic wait_for_checks();
        while (frames_checked < frames_written) begin
            @(posedge clock);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // DUT, clock and run limit
    ////////////////////////////////////////////////////////////

    rmii_transmitter dut_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .write_data   (write_data),
        .write_last   (write_last),
        .write_enable (write_enable),
        .full         (full),
        .speed_code   (speed_code),
        .txd          (txd),
        .tx_en        (tx_en)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d of %0d frames checked, errors %0d/%0d",
                cycle_count, frames_checked, frames_written, value_errors, structural_errors);
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // RMII line decoder
    ////////////////////////////////////////////////////////////

    // Entered on the first cycle of a dibit and left on its last cycle
    task automatic receive_dibit(input int period, output dibit_t value);
        dibit_t first;
        first = txd;
        value = txd;
        for (int i = 1; i < period; i++) begin
            @(negedge clock);
            if (!tx_en) begin
                report_error("tx_en fell inside a dibit period");
            end
            if (i == period / 2) begin
                value = txd;
            end
            check_dibit("txd", txd, first);
        end
    endtask

    initial begin : line_decoder
        speed_code_t    frame_speed;
        int             period;
        int             length;
        int             end_cycle;
        logic           seen_frame;
        logic           broken;
        dibit_t         symbol;
        octet_t         assembled;
        seen_frame = 1'b0;
        end_cycle  = 0;
        forever begin
            @(negedge clock);
            if (reset_n && tx_en) begin
                if (seen_frame && (cycle_count - end_cycle) < int'(INTER_PACKET_GAP_CYCLES)) begin
                    report_error($sformatf("gap of %0d cycles between frames is too short",
                        cycle_count - end_cycle));
                end
                if (expected_speeds.size() == 0) begin
                    report_error("frame on the line that was never written");
                    frame_speed = SPEED_CODE_100_MEGABIT;
                end
                else begin
                    frame_speed = expected_speeds.pop_front();
                end
                period = (frame_speed == SPEED_CODE_10_MEGABIT) ? 10 : 1;
                broken = 1'b0;
                length = 0;

                // Preamble run, then the start-of-frame dibit
                while (tx_en && txd == 2'b01) begin
                    @(negedge clock);
                end
                if (!tx_en || txd !== 2'b11) begin
                    report_error("no 11 start-of-frame dibit after the preamble");
                    broken = 1'b1;
                end
                else begin
                    receive_dibit(period, symbol);
                    @(negedge clock);
                end

                while (!broken && tx_en) begin
                    assembled = '0;
                    for (int k = 0; k < 4; k++) begin
                        if (!broken && !tx_en) begin
                            report_error("tx_en fell inside a byte");
                            broken = 1'b1;
                        end
                        else if (!broken) begin
                            receive_dibit(period, symbol);
                            assembled[2*k +: 2] = symbol;
                            @(negedge clock);
                        end
                    end
                    if (!broken) begin
                        received_bytes.push_back(assembled);
                        length++;
                    end
                end
                while (tx_en) begin
                    @(negedge clock);
                end
                end_cycle  = cycle_count;
                seen_frame = 1'b1;
                received_lengths.push_back(length);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame comparison
    ////////////////////////////////////////////////////////////

    initial begin : frame_compare
        octet_t expected_frame[$];
        octet_t received_frame[$];
        int     expected_length;
        int     received_length;
        crc_t   received_fcs;
        forever begin
            @(negedge clock);
            while (received_lengths.size() != 0) begin
                received_length = received_lengths.pop_front();
                received_frame.delete();
                expected_frame.delete();
                for (int i = 0; i < received_length; i++) begin
                    received_frame.push_back(received_bytes.pop_front());
                end
                expected_length = 0;
                if (expected_lengths.size() == 0) begin
                    report_error("received a frame with no written frame left to match");
                end
                else begin
                    expected_length = expected_lengths.pop_front();
                end
                for (int i = 0; i < expected_length; i++) begin
                    expected_frame.push_back(expected_bytes.pop_front());
                end

                if (received_length != expected_length + 4) begin
                    report_error($sformatf("frame %0d has %0d bytes on the line, expected %0d",
                        frames_checked, received_length, expected_length + 4));
                end
                for (int i = 0; i < expected_length && i < received_length; i++) begin
                    check_octet($sformatf("txd byte %0d of frame %0d", i, frames_checked),
                        received_frame[i], expected_frame[i]);
                end
                if (received_length == expected_length + 4) begin
                    received_fcs = {received_frame[expected_length + 3],
                                    received_frame[expected_length + 2],
                                    received_frame[expected_length + 1],
                                    received_frame[expected_length]};
                    check_crc($sformatf("fcs of frame %0d", frames_checked),
                        received_fcs, crc32_of(expected_frame));
                end
                frames_checked++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin : stimulus
        seed         = 12245;
        reset_n      = 1'b0;
        write_data   = '0;
        write_last   = 1'b0;
        write_enable = 1'b0;
        speed_code   = SPEED_CODE_100_MEGABIT;
        repeat (16) @(posedge clock);
        #5;
        reset_n = 1'b1;

        // Idle line after reset
        check_dibit("txd", txd, 2'b00);
        check_level("tx_en", tx_en, 1'b0);
        check_level("full", full, 1'b0);

        // Single frames at 100 Mbit/s
        repeat (3) begin
            write_random_frame();
            wait_for_checks();
        end

        // Back to back at 100 Mbit/s, then at 10 Mbit/s
        repeat (4) write_random_frame();
        wait_for_checks();
        set_speed(SPEED_CODE_10_MEGABIT);
        repeat (2) write_random_frame();
        wait_for_checks();

        // Speed switched while a frame is on the line
        set_speed(SPEED_CODE_100_MEGABIT);
        write_random_frame();
        while (!tx_en) begin
            @(posedge clock);
        end
        set_speed(SPEED_CODE_10_MEGABIT);
        write_random_frame();
        wait_for_checks();

        // Buffer overflow at 10 Mbit/s
        fill_buffer_frame();
        wait_for_checks();

        $display("frames checked: %0d, value errors: %0d, structural errors: %0d",
            frames_checked, value_errors, structural_errors);
        if (value_errors == 0 && structural_errors == 0 && expected_speeds.size() == 0) begin
            $display("Test OK");
        end
        else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/rmii_types_pkg.sv
design/rmii_timing_pkg.sv
design/tx_byte_fifo.sv
design/fcs_appender.sv
design/rmii_byte_shipper.sv
design/rmii_transmitter.sv
verification/rmii_transmitter_tb.sv
